// File: common/sv32_pkg.sv
// sv32 translation types
package sv32_pkg;

  // tlb geometry
  localparam int tlb_entries = 8;
  localparam int tlb_index_w = 3;

  // sv32 address split
  localparam int page_offset_w = 12;
  localparam int vpn_seg_w = 10;
  localparam int vpn_w = 2 * vpn_seg_w;
  localparam int tlb_tag_w = vpn_w - tlb_index_w;

  // virtual address, 34-bit physical address, physical page number
  typedef logic [31:0] va_t;
  typedef logic [33:0] pa_t;
  typedef logic [21:0] ppn_t;

  // kind of access being translated
  typedef enum logic [1:0] {
    access_load  = 2'b00,
    access_store = 2'b01,
    access_insn  = 2'b10
  } access_t;

  // privilege encoding as in mstatus.mpp
  typedef enum logic [1:0] {
    u_mode = 2'b00,
    s_mode = 2'b01,
    m_mode = 2'b11
  } priv_t;

  // privilege context seen by the checkers
  typedef struct packed {
    priv_t cur_priv;
    logic  mxr;
    logic  sum;
    logic  mprv;
    priv_t mpp;
  } priv_ctx_t;

  // low 10 bits of a pte, valid in bit 0
  typedef struct packed {
    logic [1:0] rsw;
    logic       dirty;
    logic       accessed;
    logic       global;
    logic       user;
    logic       executable;
    logic       writable;
    logic       readable;
    logic       valid;
  } pte_perms_t;

  typedef struct packed {
    ppn_t       ppn;
    pte_perms_t perms;
  } pte_t;

  // one bit per access kind
  typedef struct packed {
    logic load;
    logic store;
    logic insn;
  } page_fault_t;

endpackage

// File: common/pte_mem_if.sv
// pte read port
interface pte_mem_if;

  // request side, rd_req is a single-cycle pulse
  logic          rd_req;
  sv32_pkg::pa_t rd_addr;

  // response side, one rd_valid pulse per rd_req
  logic           rd_valid;
  sv32_pkg::pte_t rd_data;

  // walker issues reads and takes the returned pte
  modport walker (
    output rd_req,
    output rd_addr,
    input  rd_valid,
    input  rd_data
  );

  // memory side of the same port
  modport port (
    input  rd_req,
    input  rd_addr,
    output rd_valid,
    output rd_data
  );

endinterface

// File: src/page_perm_check.sv
// page permission checker
module page_perm_check (
  input  logic                  check,
  input  logic                  level,
  input  sv32_pkg::access_t     access,
  input  sv32_pkg::pte_t        pte,
  input  sv32_pkg::priv_ctx_t   ctx,
  output sv32_pkg::page_fault_t fault,
  output logic                  leaf
);

  sv32_pkg::pte_perms_t  perms;
  sv32_pkg::page_fault_t kind_fault;
  sv32_pkg::priv_t       eff_priv;
  logic                  malformed;
  logic                  is_pointer;
  logic                  user_bad;
  logic                  misaligned;

  assign perms = pte.perms;

  // fault pattern that flags only the requesting access kind
  assign kind_fault.load  = (access == sv32_pkg::access_load);
  assign kind_fault.store = (access == sv32_pkg::access_store);
  assign kind_fault.insn  = (access == sv32_pkg::access_insn);

  // invalid, w without r, or rsw bits in use
  assign malformed = !perms.valid || (!perms.readable && perms.writable) || (|perms.rsw);

  // no r/w/x means the entry points at the next table
  assign is_pointer = !(perms.readable || perms.writable || perms.executable);

  // mprv makes m-mode loads and stores use mpp
  // fetches always run at the current level
  always_comb begin
    eff_priv = ctx.cur_priv;
    if (ctx.cur_priv == sv32_pkg::m_mode && ctx.mprv && access != sv32_pkg::access_insn) begin
      eff_priv = ctx.mpp;
    end
  end

  // s-mode touches a user page only for data and only with sum
  // u-mode never touches a supervisor page
  assign user_bad = (perms.user && eff_priv == sv32_pkg::s_mode &&
                     (access == sv32_pkg::access_insn || !ctx.sum)) ||
                    (!perms.user && eff_priv == sv32_pkg::u_mode);

  // megapage must start on a 4 MiB boundary
  assign misaligned = level && (|pte.ppn[sv32_pkg::vpn_seg_w-1:0]);

  always_comb begin
    fault = '0;
    leaf  = 1'b0;
    if (check) begin
      if (malformed) begin
        fault = kind_fault;
      end else if (!level && is_pointer) begin
        // pointer found where a leaf has to be
        fault = kind_fault;
      end else if (perms.readable || perms.executable) begin
        leaf = 1'b1;
        // mxr lets loads read execute-only pages
        if (access == sv32_pkg::access_load && !perms.readable && !ctx.mxr) begin
          fault.load = 1'b1;
        end else if (access == sv32_pkg::access_insn && !perms.executable) begin
          fault.insn = 1'b1;
        end else if (access == sv32_pkg::access_store && !perms.writable) begin
          fault.store = 1'b1;
        end else if (user_bad) begin
          fault = kind_fault;
        end else if (misaligned) begin
          fault = kind_fault;
        end else if (!perms.accessed) begin
          // svade, no hardware a-bit update
          fault = kind_fault;
        end else if (access == sv32_pkg::access_store && !perms.dirty) begin
          // svade, no hardware d-bit update
          fault.store = 1'b1;
        end
      end
      // pointer at level 1 falls through, the walk descends
    end
  end

endmodule

// File: src/sv32_tlb.sv
// direct-mapped sv32 tlb
module sv32_tlb (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  sv32_pkg::va_t         vaddr,
  input  sv32_pkg::access_t     access,
  input  sv32_pkg::priv_ctx_t   ctx,
  input  logic                  satp_mode,
  input  logic                  flush,
  input  logic                  fill,
  input  logic [19:0]           fill_vpn,
  input  sv32_pkg::pte_t        fill_pte,
  input  logic                  fill_level,
  output logic                  hit_done,
  output sv32_pkg::pa_t         hit_paddr,
  output sv32_pkg::page_fault_t hit_fault,
  output logic                  miss,
  output sv32_pkg::va_t         miss_vaddr,
  output sv32_pkg::access_t     miss_access
);

  // entry storage
  logic [sv32_pkg::tlb_entries-1:0] valid_q;
  logic [sv32_pkg::tlb_entries-1:0] level_q;
  logic [sv32_pkg::tlb_tag_w-1:0]   tag_q [sv32_pkg::tlb_entries];
  sv32_pkg::pte_t                   pte_q [sv32_pkg::tlb_entries];

  logic [sv32_pkg::vpn_w-1:0]       vpn;
  logic [sv32_pkg::tlb_index_w-1:0] idx;
  logic [sv32_pkg::tlb_index_w-1:0] fill_idx;
  logic [sv32_pkg::tlb_tag_w-1:0]   tag;
  logic                             tag_match;
  logic                             lookup_hit;
  sv32_pkg::pte_t                   hit_pte;
  sv32_pkg::page_fault_t            chk_fault;
  logic                             chk_leaf;
  sv32_pkg::pa_t                    tr_paddr;

  // index with the low vpn bits, the rest is the tag
  assign vpn      = vaddr[31:sv32_pkg::page_offset_w];
  assign idx      = vpn[sv32_pkg::tlb_index_w-1:0];
  assign tag      = vpn[sv32_pkg::vpn_w-1:sv32_pkg::tlb_index_w];
  assign fill_idx = fill_vpn[sv32_pkg::tlb_index_w-1:0];
  assign hit_pte  = pte_q[idx];

  // megapage entries compare vpn[1] only
  assign tag_match = level_q[idx] ?
    (tag_q[idx][sv32_pkg::tlb_tag_w-1 -: sv32_pkg::vpn_seg_w] ==
     tag[sv32_pkg::tlb_tag_w-1 -: sv32_pkg::vpn_seg_w]) :
    (tag_q[idx] == tag);

  assign lookup_hit = req && satp_mode && valid_q[idx] && tag_match;

  // context may have changed since the fill so check again
  page_perm_check chk_i (
    .check  (lookup_hit),
    .level  (level_q[idx]),
    .access (access),
    .pte    (hit_pte),
    .ctx    (ctx),
    .fault  (chk_fault),
    .leaf   (chk_leaf)
  );

  // page or megapage address
  always_comb begin
    if (level_q[idx]) begin
      tr_paddr = {hit_pte.ppn[21:sv32_pkg::vpn_seg_w],
                  vaddr[sv32_pkg::vpn_seg_w+sv32_pkg::page_offset_w-1:0]};
    end else begin
      tr_paddr = {hit_pte.ppn, vaddr[sv32_pkg::page_offset_w-1:0]};
    end
  end

  // flush drops every entry and wins over a fill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (flush) begin
      valid_q <= '0;
    end else if (fill) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tag_q[fill_idx]   <= fill_vpn[sv32_pkg::vpn_w-1:sv32_pkg::tlb_index_w];
      pte_q[fill_idx]   <= fill_pte;
      level_q[fill_idx] <= fill_level;
    end
  end

  // result stage, bare mode always completes here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hit_done  <= 1'b0;
      miss      <= 1'b0;
      hit_fault <= '0;
    end else begin
      hit_done <= req && (!satp_mode || lookup_hit);
      miss     <= req && satp_mode && !lookup_hit;
      if (req) begin
        hit_fault <= chk_fault;
      end
    end
  end

  // faulting translations report a zero address
  always_ff @(posedge clk) begin
    if (req) begin
      miss_vaddr  <= vaddr;
      miss_access <= access;
      if (!satp_mode) begin
        hit_paddr <= {2'b00, vaddr};
      end else if (|chk_fault) begin
        hit_paddr <= '0;
      end else begin
        hit_paddr <= tr_paddr;
      end
    end
  end

  // busy holds req off for the whole walk so a refill never meets a lookup
  a_fill_no_req: assert property (@(posedge clk) disable iff (!rst_n) fill |-> !req);

  a_done_or_miss: assert property (@(posedge clk) disable iff (!rst_n) !(hit_done && miss));

  // only checked leaves are ever refilled
  a_hit_is_leaf: assert property (@(posedge clk) disable iff (!rst_n) lookup_hit |-> chk_leaf);

endmodule

// File: walker/sv32_walker.sv
// sv32 page table walker
module sv32_walker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  miss,
  input  sv32_pkg::va_t         miss_vaddr,
  input  sv32_pkg::access_t     miss_access,
  input  sv32_pkg::priv_ctx_t   ctx,
  input  sv32_pkg::ppn_t        satp_ppn,
  pte_mem_if.walker             mem,
  output logic                  fill,
  output logic [19:0]           fill_vpn,
  output sv32_pkg::pte_t        fill_pte,
  output logic                  fill_level,
  output logic                  walk_done,
  output sv32_pkg::pa_t         walk_paddr,
  output sv32_pkg::page_fault_t walk_fault,
  output logic                  busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_read_l1,
    st_read_l0,
    st_finish
  } state_t;

  state_t                state;
  sv32_pkg::va_t         va_q;
  sv32_pkg::access_t     access_q;
  logic                  level;
  sv32_pkg::page_fault_t chk_fault;
  logic                  chk_leaf;
  logic                  walk_end;
  sv32_pkg::pa_t         leaf_paddr;

  // level 1 while the root table read is out
  assign level = (state == st_read_l1);

  // returned pte is checked the cycle it arrives
  page_perm_check chk_i (
    .check  (mem.rd_valid),
    .level  (level),
    .access (access_q),
    .pte    (mem.rd_data),
    .ctx    (ctx),
    .fault  (chk_fault),
    .leaf   (chk_leaf)
  );

  // leaf or fault ends the walk, a clean pointer descends
  assign walk_end = mem.rd_valid && (chk_leaf || (|chk_fault));

  always_comb begin
    if (level) begin
      leaf_paddr = {mem.rd_data.ppn[21:sv32_pkg::vpn_seg_w],
                    va_q[sv32_pkg::vpn_seg_w+sv32_pkg::page_offset_w-1:0]};
    end else begin
      leaf_paddr = {mem.rd_data.ppn, va_q[sv32_pkg::page_offset_w-1:0]};
    end
  end

  // control fsm
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      mem.rd_req <= 1'b0;
      walk_fault <= '0;
    end else begin
      // rd_req is a one-cycle pulse
      mem.rd_req <= 1'b0;
      case (state)
        st_idle: begin
          if (miss) begin
            state      <= st_read_l1;
            mem.rd_req <= 1'b1;
          end
        end
        st_read_l1: begin
          if (walk_end) begin
            state      <= st_finish;
            walk_fault <= chk_fault;
          end else if (mem.rd_valid) begin
            state      <= st_read_l0;
            mem.rd_req <= 1'b1;
          end
        end
        st_read_l0: begin
          // level 0 always gives a leaf or a fault
          if (mem.rd_valid) begin
            state      <= st_finish;
            walk_fault <= chk_fault;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // request address and leaf result
  always_ff @(posedge clk) begin
    if (state == st_idle && miss) begin
      va_q        <= miss_vaddr;
      access_q    <= miss_access;
      mem.rd_addr <= {satp_ppn, miss_vaddr[31 -: sv32_pkg::vpn_seg_w], 2'b00};
    end
    if (state == st_read_l1 && mem.rd_valid && !walk_end) begin
      mem.rd_addr <= {mem.rd_data.ppn, va_q[sv32_pkg::page_offset_w +: sv32_pkg::vpn_seg_w],
                      2'b00};
    end
    if (walk_end) begin
      walk_paddr <= (|chk_fault) ? '0 : leaf_paddr;
      fill_pte   <= mem.rd_data;
      fill_level <= level;
    end
  end

  assign fill_vpn  = va_q[31:sv32_pkg::page_offset_w];
  assign walk_done = (state == st_finish);
  // faulting leaves stay out of the tlb
  assign fill      = walk_done && !(|walk_fault);
  assign busy      = (state != st_idle);

  // memory answers only an outstanding read and never in the request cycle
  a_rd_valid_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    mem.rd_valid |-> (state inside {st_read_l1, st_read_l0}) && !mem.rd_req);

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    walk_done |=> !walk_done);

  // tlb only reports a miss while the walker is free
  a_miss_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    miss |-> state == st_idle);

endmodule

// File: src/mmu_top.sv
// sv32 translation unit
module mmu_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  sv32_pkg::va_t         vaddr,
  input  sv32_pkg::access_t     access,
  input  sv32_pkg::priv_ctx_t   ctx,
  input  logic                  satp_mode,
  input  sv32_pkg::ppn_t        satp_ppn,
  input  logic                  flush,
  output logic                  done,
  output sv32_pkg::pa_t         paddr,
  output sv32_pkg::page_fault_t fault,
  output logic                  busy,
  output logic                  mem_rd_req,
  output sv32_pkg::pa_t         mem_rd_addr,
  input  logic                  mem_rd_valid,
  input  sv32_pkg::pte_t        mem_rd_data
);

  pte_mem_if mem_if ();

  logic                  req_gated;
  logic                  tlb_miss;
  sv32_pkg::va_t         miss_vaddr;
  sv32_pkg::access_t     miss_access;
  logic                  fill;
  logic [19:0]           fill_vpn;
  sv32_pkg::pte_t        fill_pte;
  logic                  fill_level;
  logic                  hit_done;
  sv32_pkg::pa_t         hit_paddr;
  sv32_pkg::page_fault_t hit_fault;
  logic                  walk_done;
  sv32_pkg::pa_t         walk_paddr;
  sv32_pkg::page_fault_t walk_fault;
  logic                  walk_busy;

  // busy from the miss pulse until the walk reports done
  assign busy      = tlb_miss || walk_busy;
  assign req_gated = req && !busy;

  sv32_tlb tlb_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req_gated),
    .vaddr       (vaddr),
    .access      (access),
    .ctx         (ctx),
    .satp_mode   (satp_mode),
    .flush       (flush),
    .fill        (fill),
    .fill_vpn    (fill_vpn),
    .fill_pte    (fill_pte),
    .fill_level  (fill_level),
    .hit_done    (hit_done),
    .hit_paddr   (hit_paddr),
    .hit_fault   (hit_fault),
    .miss        (tlb_miss),
    .miss_vaddr  (miss_vaddr),
    .miss_access (miss_access)
  );

  sv32_walker walker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .miss        (tlb_miss),
    .miss_vaddr  (miss_vaddr),
    .miss_access (miss_access),
    .ctx         (ctx),
    .satp_ppn    (satp_ppn),
    .mem         (mem_if.walker),
    .fill        (fill),
    .fill_vpn    (fill_vpn),
    .fill_pte    (fill_pte),
    .fill_level  (fill_level),
    .walk_done   (walk_done),
    .walk_paddr  (walk_paddr),
    .walk_fault  (walk_fault),
    .busy        (walk_busy)
  );

  // external memory port
  assign mem_rd_req      = mem_if.rd_req;
  assign mem_rd_addr     = mem_if.rd_addr;
  assign mem_if.rd_valid = mem_rd_valid;
  assign mem_if.rd_data  = mem_rd_data;

  // hit and walk results never coincide
  assign done  = hit_done || walk_done;
  assign paddr = walk_done ? walk_paddr : hit_paddr;
  assign fault = walk_done ? walk_fault : hit_fault;

  a_one_result: assert property (@(posedge clk) disable iff (!rst_n) !(hit_done && walk_done));

endmodule

// File: tb/tb_clock.sv
// testbench clock and reset
module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 10-unit period, first rising edge at 5
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // reset spans three rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: tb/mmu_tb.sv
// sv32 mmu testbench
module mmu_tb;

  localparam int n_requests = 33;
  localparam int max_cycles = 64 * n_requests + 16;
  localparam logic [21:0] root_ppn = 22'h000010;
  localparam logic [21:0] l0_ppn = 22'h000011;

  // test pages built as {vpn1, vpn0, offset}
  localparam sv32_pkg::va_t va_page  = {10'd1, 10'd0, 12'h5c4};
  localparam sv32_pkg::va_t va_ptr0  = {10'd1, 10'd1, 12'h5c4};
  localparam sv32_pkg::va_t va_xonly = {10'd1, 10'd2, 12'h5c4};
  localparam sv32_pkg::va_t va_user  = {10'd1, 10'd3, 12'h5c4};
  localparam sv32_pkg::va_t va_no_a  = {10'd1, 10'd4, 12'h5c4};
  localparam sv32_pkg::va_t va_no_d  = {10'd1, 10'd5, 12'h5c4};
  localparam sv32_pkg::va_t va_mega  = {10'd2, 10'h016, 12'h5c4};
  localparam sv32_pkg::va_t va_misal = {10'd3, 10'd7, 12'h5c4};
  localparam sv32_pkg::va_t va_inval = {10'd4, 10'd0, 12'h5c4};
  localparam sv32_pkg::va_t va_wonly = {10'd5, 10'd0, 12'h5c4};
  localparam sv32_pkg::va_t va_rsw   = {10'd6, 10'd0, 12'h5c4};

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  sv32_pkg::va_t         vaddr;
  sv32_pkg::access_t     access;
  sv32_pkg::priv_ctx_t   ctx;
  logic                  satp_mode;
  sv32_pkg::ppn_t        satp_ppn;
  logic                  flush;
  logic                  done;
  sv32_pkg::pa_t         paddr;
  sv32_pkg::page_fault_t fault;
  logic                  busy;
  logic                  mem_rd_req;
  sv32_pkg::pa_t         mem_rd_addr;
  logic                  mem_rd_valid;
  sv32_pkg::pte_t        mem_rd_data;

  // page table memory holds the root table then the level 0 table
  sv32_pkg::pte_t pt_mem [0:2047];
  sv32_pkg::pa_t  held_addr;
  int             wait_cnt;
  int             rd_count;
  logic [1:0]     delay;
  logic [15:0]    lfsr;

  // tlb model and expected result of the request in flight
  logic [7:0]            tlb_valid;
  logic [7:0]            tlb_level;
  logic [19:0]           tlb_vpn [8];
  sv32_pkg::pte_t        tlb_pte [8];
  logic                  pending;
  logic                  exp_quick;
  int                    exp_reads;
  sv32_pkg::pa_t         exp_paddr;
  sv32_pkg::page_fault_t exp_fault;
  sv32_pkg::pa_t         exp_addr_l1;
  sv32_pkg::pa_t         exp_addr_l0;

  int value_errors;
  int protocol_errors;
  int req_count;
  int cycle_count;

  tb_clock clock_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mmu_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .vaddr        (vaddr),
    .access       (access),
    .ctx          (ctx),
    .satp_mode    (satp_mode),
    .satp_ppn     (satp_ppn),
    .flush        (flush),
    .done         (done),
    .paddr        (paddr),
    .fault        (fault),
    .busy         (busy),
    .mem_rd_req   (mem_rd_req),
    .mem_rd_addr  (mem_rd_addr),
    .mem_rd_valid (mem_rd_valid),
    .mem_rd_data  (mem_rd_data)
  );

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // word index inside the two table pages
  function automatic logic [10:0] mem_index(input sv32_pkg::pa_t a);
    return a[12:2];
  endfunction

  function automatic sv32_pkg::priv_ctx_t make_ctx(input sv32_pkg::priv_t p, input logic mxr,
                                                   input logic sum, input logic mprv,
                                                   input sv32_pkg::priv_t mpp);
    sv32_pkg::priv_ctx_t c;
    c.cur_priv = p;
    c.mxr      = mxr;
    c.sum      = sum;
    c.mprv     = mprv;
    c.mpp      = mpp;
    return c;
  endfunction

  // true when one pte faults the access under sv32 rules
  function automatic logic pte_faults(input sv32_pkg::pte_t p, input logic lvl,
                                      input sv32_pkg::access_t acc,
                                      input sv32_pkg::priv_ctx_t c, output logic is_leaf);
    sv32_pkg::pte_perms_t f;
    sv32_pkg::priv_t      eff;
    logic                 ok;
    f = p.perms;
    is_leaf = f.readable || f.executable;
    // mprv moves only data accesses to mpp
    eff = (c.cur_priv == sv32_pkg::m_mode && c.mprv && acc != sv32_pkg::access_insn) ?
          c.mpp : c.cur_priv;
    if (!f.valid || (f.writable && !f.readable) || f.rsw != 2'b00) begin
      return 1'b1;
    end
    // pointer descends at level 1 and faults at level 0
    if (!is_leaf) begin
      return !lvl;
    end
    case (acc)
      sv32_pkg::access_load:  ok = f.readable || (c.mxr && f.executable);
      sv32_pkg::access_store: ok = f.writable && f.dirty;
      default:                ok = f.executable;
    endcase
    if (eff == sv32_pkg::u_mode && !f.user) begin
      ok = 1'b0;
    end
    if (eff == sv32_pkg::s_mode && f.user && (acc == sv32_pkg::access_insn || !c.sum)) begin
      ok = 1'b0;
    end
    return !ok || !f.accessed || (lvl && p.ppn[9:0] != 10'd0);
  endfunction

  // reference translation that keeps the tlb model in step
  task automatic predict(input sv32_pkg::va_t va, input sv32_pkg::access_t acc);
    logic [2:0]     idx;
    sv32_pkg::pte_t p;
    logic           lvl;
    logic           bad;
    logic           lf;
    logic           hit;
    idx = va[14:12];
    hit = tlb_valid[idx] && (tlb_level[idx] ? tlb_vpn[idx][19:10] == va[31:22] :
                                              tlb_vpn[idx] == va[31:12]);
    exp_reads = 0;
    exp_quick = 1'b1;
    exp_addr_l1 = {satp_ppn, va[31:22], 2'b00};
    exp_addr_l0 = '0;
    bad = 1'b0;
    lvl = 1'b0;
    p = '0;
    if (satp_mode && hit) begin
      p = tlb_pte[idx];
      lvl = tlb_level[idx];
      bad = pte_faults(p, lvl, acc, ctx, lf);
    end else if (satp_mode) begin
      exp_quick = 1'b0;
      exp_reads = 1;
      lvl = 1'b1;
      p = pt_mem[mem_index(exp_addr_l1)];
      bad = pte_faults(p, 1'b1, acc, ctx, lf);
      if (!bad && !lf) begin
        exp_reads = 2;
        lvl = 1'b0;
        exp_addr_l0 = {p.ppn, va[21:12], 2'b00};
        p = pt_mem[mem_index(exp_addr_l0)];
        bad = pte_faults(p, 1'b0, acc, ctx, lf);
      end
      // only clean leaves are cached
      if (!bad) begin
        tlb_valid[idx] = 1'b1;
        tlb_level[idx] = lvl;
        tlb_vpn[idx]   = va[31:12];
        tlb_pte[idx]   = p;
      end
    end
    if (!satp_mode) begin
      exp_paddr = {2'b00, va};
    end else if (lvl) begin
      exp_paddr = {p.ppn[21:10], va[21:0]};
    end else begin
      exp_paddr = {p.ppn, va[11:0]};
    end
    exp_fault.load  = bad && acc == sv32_pkg::access_load;
    exp_fault.store = bad && acc == sv32_pkg::access_store;
    exp_fault.insn  = bad && acc == sv32_pkg::access_insn;
  endtask

  // one request that starts and returns on a falling edge
  task automatic translate(input sv32_pkg::va_t va, input sv32_pkg::access_t acc,
                           input logic stray);
    logic sent;
    sent = 1'b0;
    predict(va, acc);
    rd_count = 0;
    pending = 1'b1;
    req_count = req_count + 1;
    req = 1'b1;
    vaddr = va;
    access = acc;
    @(negedge clk);
    req = 1'b0;
    while (!done) begin
      // extra request while busy that the dut has to drop
      if (stray && busy && !sent) begin
        req = 1'b1;
        vaddr = va ^ 32'h0040_3000;
        sent = 1'b1;
      end
      @(negedge clk);
      req = 1'b0;
    end
    @(negedge clk);
    pending = 1'b0;
  endtask

  task automatic flush_tlb();
    flush = 1'b1;
    tlb_valid = '0;
    @(negedge clk);
    flush = 1'b0;
  endtask

  task automatic place(input logic [21:0] tbl, input logic [9:0] vpn,
                       input logic [21:0] ppn, input logic [9:0] perms);
    pt_mem[mem_index({tbl, vpn, 2'b00})] = {ppn, perms};
  endtask

  // memory port answers 1 to 4 cycles after rd_req
  always @(negedge clk) begin
    mem_rd_valid = 1'b0;
    if (wait_cnt > 0) begin
      wait_cnt = wait_cnt - 1;
      if (wait_cnt == 0) begin
        mem_rd_valid = 1'b1;
        mem_rd_data = pt_mem[mem_index(held_addr)];
      end
    end
    if (mem_rd_req) begin
      held_addr = mem_rd_addr;
      rd_count = rd_count + 1;
      lfsr = lfsr_next(lfsr);
      delay[0] = lfsr[0];
      lfsr = lfsr_next(lfsr);
      delay[1] = lfsr[0];
      wait_cnt = 1 + int'(delay);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: no done within %0d cycles, a request hung", max_cycles);
      $display("requests %0d, value errors %0d, protocol errors %0d",
               req_count, value_errors, protocol_errors);
      $display("Something failed");
      $finish;
    end
  end

  // outputs stay low while reset is held
  a_reset_idle: assert property (@(posedge clk)
    !rst_n && $past(!rst_n) |-> !done && !busy && !mem_rd_req)
    else begin
      protocol_errors = protocol_errors + 1;
      $display("Error at %0t: done, busy or mem_rd_req high during reset", $time);
    end

  // hit and bare mode finish one cycle after req
  a_quick: assert property (@(posedge clk) disable iff (!rst_n)
    req && !busy && exp_quick |=> done)
    else begin
      protocol_errors = protocol_errors + 1;
      $display("Error at %0t: hit or bare request gave no done after one cycle", $time);
    end

  // busy rises the cycle after a miss and holds until done
  a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
    req && !busy && !exp_quick |=> busy)
    else begin
      protocol_errors = protocol_errors + 1;
      $display("Error at %0t: busy stayed low after a tlb miss", $time);
    end

  a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n) busy && !done |=> busy)
    else begin
      protocol_errors = protocol_errors + 1;
      $display("Error at %0t: busy dropped before done", $time);
    end

  // no walk in flight means busy low
  a_busy_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (!pending || exp_quick) |-> !busy)
    else begin
      protocol_errors = protocol_errors + 1;
      $display("Error at %0t: busy high without a walk", $time);
    end

  a_expected_done: assert property (@(posedge clk) disable iff (!rst_n) done |-> pending)
    else begin
      protocol_errors = protocol_errors + 1;
      $display("Error at %0t: done without an outstanding request", $time);
    end

  // root entry on the first read and level 0 entry on the second
  a_rd_addr: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rd_req |-> mem_rd_addr == (rd_count == 1 ? exp_addr_l1 : exp_addr_l0))
    else begin
      value_errors = value_errors + 1;
      $display("Error at %0t: read address %h, expected %h", $time, $sampled(mem_rd_addr),
               ($sampled(rd_count) == 1) ? exp_addr_l1 : exp_addr_l0);
    end

  a_fault: assert property (@(posedge clk) disable iff (!rst_n) done |-> fault == exp_fault)
    else begin
      value_errors = value_errors + 1;
      $display("Error at %0t: fault %b, expected %b", $time, $sampled(fault), exp_fault);
    end

  a_paddr: assert property (@(posedge clk) disable iff (!rst_n)
    done && exp_fault == 3'b000 |-> paddr == exp_paddr)
    else begin
      value_errors = value_errors + 1;
      $display("Error at %0t: paddr %h, expected %h", $time, $sampled(paddr), exp_paddr);
    end

  a_reads: assert property (@(posedge clk) disable iff (!rst_n) done |-> rd_count == exp_reads)
    else begin
      value_errors = value_errors + 1;
      $display("Error at %0t: %0d memory reads, expected %0d", $time, rd_count, exp_reads);
    end

  initial begin
    value_errors = 0;
    protocol_errors = 0;
    req_count = 0;
    cycle_count = 0;
    rd_count = 0;
    wait_cnt = 0;
    lfsr = 16'd47630;
    req = 1'b0;
    vaddr = '0;
    access = sv32_pkg::access_load;
    ctx = make_ctx(sv32_pkg::s_mode, 1'b0, 1'b0, 1'b0, sv32_pkg::u_mode);
    satp_mode = 1'b0;
    satp_ppn = root_ppn;
    flush = 1'b0;
    mem_rd_valid = 1'b0;
    mem_rd_data = '0;
    pending = 1'b0;
    exp_quick = 1'b0;
    exp_reads = 0;
    exp_paddr = '0;
    exp_fault = '0;
    exp_addr_l1 = '0;
    exp_addr_l0 = '0;
    tlb_valid = '0;
    // invalid background with the ppn taken from the index
    for (int i = 0; i < 2048; i++) begin
      pt_mem[i] = {22'(i) ^ 22'h2a5a5, 10'h000};
    end
    place(root_ppn, 10'd1, l0_ppn, 10'h001);
    place(root_ppn, 10'd2, 22'h000400, 10'h0cf);
    place(root_ppn, 10'd3, 22'h000401, 10'h0cf);
    place(root_ppn, 10'd5, 22'h000123, 10'h0c5);
    place(root_ppn, 10'd6, 22'h000400, 10'h3cf);
    place(l0_ppn, 10'd0, 22'h000123, 10'h0c7);
    place(l0_ppn, 10'd1, 22'h000124, 10'h001);
    place(l0_ppn, 10'd2, 22'h000125, 10'h049);
    place(l0_ppn, 10'd3, 22'h000126, 10'h0df);
    place(l0_ppn, 10'd4, 22'h000127, 10'h087);
    place(l0_ppn, 10'd5, 22'h000128, 10'h047);
    @(posedge rst_n);
    @(negedge clk);

    translate(32'h8765_4321, sv32_pkg::access_load, 1'b0);
    translate(32'hfedc_ba98, sv32_pkg::access_insn, 1'b0);
    satp_mode = 1'b1;
    // two-level walk followed by a hit
    translate(va_page, sv32_pkg::access_load, 1'b0);
    translate(va_page + 32'h10, sv32_pkg::access_store, 1'b0);
    translate(va_mega, sv32_pkg::access_load, 1'b0);
    translate(va_mega, sv32_pkg::access_insn, 1'b0);
    translate(va_misal, sv32_pkg::access_load, 1'b0);
    translate(va_misal, sv32_pkg::access_store, 1'b0);
    // malformed entries walk again on each retry
    repeat (2) translate(va_inval, sv32_pkg::access_load, 1'b0);
    repeat (2) translate(va_wonly, sv32_pkg::access_store, 1'b0);
    repeat (2) translate(va_rsw, sv32_pkg::access_insn, 1'b0);
    repeat (2) translate(va_ptr0, sv32_pkg::access_load, 1'b0);
    // recheck of cached entries under a new context
    translate(va_xonly, sv32_pkg::access_insn, 1'b0);
    translate(va_xonly, sv32_pkg::access_load, 1'b0);
    ctx = make_ctx(sv32_pkg::s_mode, 1'b1, 1'b0, 1'b0, sv32_pkg::u_mode);
    translate(va_xonly, sv32_pkg::access_load, 1'b0);
    translate(va_xonly, sv32_pkg::access_store, 1'b0);
    translate(va_page, sv32_pkg::access_insn, 1'b0);
    ctx = make_ctx(sv32_pkg::s_mode, 1'b0, 1'b1, 1'b0, sv32_pkg::u_mode);
    translate(va_user, sv32_pkg::access_load, 1'b0);
    ctx = make_ctx(sv32_pkg::s_mode, 1'b0, 1'b0, 1'b0, sv32_pkg::u_mode);
    translate(va_user, sv32_pkg::access_load, 1'b0);
    ctx = make_ctx(sv32_pkg::s_mode, 1'b0, 1'b1, 1'b0, sv32_pkg::u_mode);
    translate(va_user, sv32_pkg::access_insn, 1'b0);
    ctx = make_ctx(sv32_pkg::u_mode, 1'b0, 1'b0, 1'b0, sv32_pkg::u_mode);
    translate(va_user, sv32_pkg::access_store, 1'b0);
    translate(va_page, sv32_pkg::access_load, 1'b0);
    ctx = make_ctx(sv32_pkg::m_mode, 1'b0, 1'b0, 1'b1, sv32_pkg::u_mode);
    translate(va_page, sv32_pkg::access_load, 1'b0);
    translate(va_user, sv32_pkg::access_insn, 1'b0);
    ctx = make_ctx(sv32_pkg::m_mode, 1'b0, 1'b0, 1'b1, sv32_pkg::s_mode);
    translate(va_page, sv32_pkg::access_store, 1'b0);
    // svade a and d bits
    ctx = make_ctx(sv32_pkg::s_mode, 1'b0, 1'b0, 1'b0, sv32_pkg::u_mode);
    translate(va_no_a, sv32_pkg::access_load, 1'b0);
    translate(va_no_d, sv32_pkg::access_load, 1'b0);
    translate(va_no_d, sv32_pkg::access_store, 1'b0);
    // flushed page walks again with a dropped request during the walk
    flush_tlb();
    translate(va_page, sv32_pkg::access_load, 1'b1);
    repeat (4) @(negedge clk);

    $display("requests %0d, value errors %0d, protocol errors %0d",
             req_count, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: build.f
common/sv32_pkg.sv
common/pte_mem_if.sv
src/page_perm_check.sv
src/sv32_tlb.sv
walker/sv32_walker.sv
src/mmu_top.sv
tb/tb_clock.sv
tb/mmu_tb.sv
